/* Makefile */
# Verilator build, run and lint of the accelerator control sequencer

VERILATOR ?= verilator
TOP       ?= tb_panda_ctrl
RTL_TOP   ?= panda_ctrl_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= panda_pkg.sv load_param_mux.sv in_packet_counter.sv \
             load_sequencer.sv out_packet_counter.sv panda_ctrl_top.sv
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
panda_pkg.sv
load_param_mux.sv
in_packet_counter.sv
load_sequencer.sv
out_packet_counter.sv
panda_ctrl_top.sv
tb_panda_ctrl.sv

/* in_packet_counter.sv */
// Input packet counter of the load chain
// Registered region clear, packet count per region
// Stream ready and memory write enable, zero and complete flags

module in_packet_counter import panda_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  clear_i,
   input  logic  load_clear_i,   // From sequencer, applied one cycle later
   input  logic  load_active_i,
   input  word_t trans_size_i,
   input  logic  a_valid_i,
   input  logic  b_valid_i,
   output logic  stream_ready_o,
   output logic  wr_en_o,
   output logic  count_zero_o,
   output logic  complete_o
);

   logic  clear_q;
   word_t count_q;
   logic  at_size;

   assign at_size = (count_q == trans_size_i);

   // Count is stale while the clear is pending
   assign complete_o   = load_active_i && !clear_q && at_size;
   assign count_zero_o = !clear_q && (count_q == '0);

   // Both streams valid, counter live, region not yet full
   assign stream_ready_o = load_active_i && !clear_q && !at_size && a_valid_i && b_valid_i;
   assign wr_en_o        = stream_ready_o;  // One write per accepted packet

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         clear_q <= 1'b1;
      end else if (clear_i) begin
         clear_q <= 1'b1;
      end else begin
         clear_q <= load_clear_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         count_q <= '0;
      end else if (clear_i || clear_q) begin
         count_q <= '0;
      end else if (stream_ready_o) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Region size from the parameter mux bounds the live count
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      (load_active_i && !clear_q) |-> (count_q <= trans_size_i))
      else $error("input packet count beyond region size");

endmodule

/* load_param_mux.sv */
// Load parameter selection
// Per load state: transfer size, address and data base, memory select
// Zero and null select outside the load chain

module load_param_mux import panda_pkg::*; (
   input  fsm_state_t  state_i,
   input  param_bank_t params_i,
   input  logic        mode_i,
   output word_t       trans_size_o,
   output word_t       a_base_o,
   output word_t       d_base_o,
   output mem_sel_t    mem_sel_o
);

   always_comb begin
      trans_size_o = '0;
      a_base_o     = '0;
      d_base_o     = '0;
      mem_sel_o    = SEL_NULL;
      unique case (state_i)
         ST_LOAD_CONFIG: begin
            trans_size_o = params_i[PRM_CONFIG_N];
            a_base_o     = params_i[PRM_CONFIG_AADDR];
            d_base_o     = params_i[PRM_CONFIG_DADDR];
            mem_sel_o    = SEL_CONFIG;
         end
         ST_LOAD_INSTR: begin
            trans_size_o = params_i[PRM_INSTR_N];
            a_base_o     = params_i[PRM_INSTR_AADDR];
            d_base_o     = params_i[PRM_INSTR_DADDR];
            mem_sel_o    = SEL_INSTR;
         end
         ST_LOAD_LUT: begin
            trans_size_o = params_i[PRM_LUT_N];
            a_base_o     = params_i[PRM_LUT_AADDR];
            d_base_o     = params_i[PRM_LUT_DADDR];
            mem_sel_o    = SEL_LUT;
         end
         ST_LOAD_SPARSITY: begin
            trans_size_o = params_i[PRM_SPARSITY_N];
            a_base_o     = params_i[PRM_SPARSITY_AADDR];
            d_base_o     = params_i[PRM_SPARSITY_DADDR];
            mem_sel_o    = SEL_SPARSITY;
         end
         ST_LOAD_ACTIVATION: begin
            trans_size_o = params_i[PRM_ACTIVATION_N];
            a_base_o     = params_i[PRM_ACTIVATION_AADDR];
            d_base_o     = params_i[PRM_ACTIVATION_DADDR];
            mem_sel_o    = SEL_ACTIVATION;
         end
         ST_LOAD_WCONV: begin  // CNN weights
            trans_size_o = params_i[PRM_WCONV_N];
            a_base_o     = params_i[PRM_WCONV_AADDR];
            d_base_o     = params_i[PRM_WCONV_DADDR];
            mem_sel_o    = SEL_WCONV;
         end
         ST_LOAD_WFC: begin    // FC weights
            trans_size_o = params_i[PRM_WFC_N];
            a_base_o     = params_i[PRM_WFC_AADDR];
            d_base_o     = params_i[PRM_WFC_DADDR];
            mem_sel_o    = SEL_WFC;
         end
         default: ;            // Idle, run and terminate keep defaults
      endcase
   end

   // Weight memory must agree with the engine mode held through the load
   always_comb begin
      if (mem_sel_o inside {SEL_WCONV, SEL_WFC}) begin
         assert ((mem_sel_o == SEL_WCONV) == (mode_i == MODE_CNN))
            else $error("weight select does not match engine mode");
      end
   end

endmodule

/* load_sequencer.sv */
// Sequencer FSM of the accelerator control
// Load chain config, instr, LUT, sparsity, activation, then conv or FC weights
// Engine clear, enable and start, input streamer start requests
// Output counter enable while running, done pulse at job end

module load_sequencer import panda_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       clear_i,
   input  logic       start_i,
   input  logic       mode_i,
   input  logic       count_zero_i,
   input  logic       complete_i,
   input  logic       a_ready_start_i,
   input  logic       b_ready_start_i,
   input  logic       engine_done_i,
   output fsm_state_t state_o,
   output logic       load_active_o,
   output logic       load_clear_o,
   output logic       run_active_o,
   output logic       a_req_start_o,
   output logic       b_req_start_o,
   output logic       engine_clear_o,
   output logic       engine_enable_o,
   output logic       engine_start_o,
   output logic       done_o
);

   fsm_state_t state_q, state_d;
   fsm_state_t next_load;   // Successor in the load chain
   logic       streamers_ready;

   assign streamers_ready = a_ready_start_i && b_ready_start_i;
   assign state_o         = state_q;

   assign load_active_o = state_q inside {ST_LOAD_CONFIG, ST_LOAD_INSTR, ST_LOAD_LUT,
                                          ST_LOAD_SPARSITY, ST_LOAD_ACTIVATION,
                                          ST_LOAD_WCONV, ST_LOAD_WFC};
   assign run_active_o  = (state_q == ST_RUNNING);

   // Level request until the first packet lands
   assign a_req_start_o = load_active_o && count_zero_i && !complete_i && streamers_ready;
   assign b_req_start_o = a_req_start_o;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= ST_IDLE;
      end else if (clear_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      unique case (state_q)
         ST_LOAD_CONFIG:     next_load = ST_LOAD_INSTR;
         ST_LOAD_INSTR:      next_load = ST_LOAD_LUT;
         ST_LOAD_LUT:        next_load = ST_LOAD_SPARSITY;
         ST_LOAD_SPARSITY:   next_load = ST_LOAD_ACTIVATION;
         ST_LOAD_ACTIVATION: begin
            // Mode picks the weight memory
            next_load = (mode_i == MODE_FC) ? ST_LOAD_WFC : ST_LOAD_WCONV;
         end
         default:            next_load = ST_RUN;  // After either weight load
      endcase
   end

   always_comb begin
      state_d         = state_q;
      load_clear_o    = 1'b1;   // Counter held clear by default
      engine_clear_o  = 1'b0;
      engine_enable_o = 1'b1;
      engine_start_o  = 1'b0;
      done_o          = 1'b0;
      unique case (state_q)
         ST_IDLE: begin
            engine_clear_o  = 1'b1;  // Engine kept in reset
            engine_enable_o = 1'b0;
            if (start_i) begin
               state_d = ST_LOAD_CONFIG;
            end
         end
         ST_LOAD_CONFIG, ST_LOAD_INSTR, ST_LOAD_LUT, ST_LOAD_SPARSITY,
         ST_LOAD_ACTIVATION, ST_LOAD_WCONV, ST_LOAD_WFC: begin
            load_clear_o = 1'b0;
            if (complete_i) begin
               load_clear_o = 1'b1;  // Region full, clear for the next one
               state_d      = next_load;
            end
         end
         ST_RUN: begin
            engine_start_o = 1'b1;
            state_d        = ST_RUNNING;
         end
         ST_RUNNING: begin
            if (engine_done_i) begin
               state_d = ST_TERMINATE;
            end
         end
         ST_TERMINATE: begin
            engine_enable_o = 1'b0;
            // Wait for the input streamers to go idle
            if (streamers_ready) begin
               done_o  = 1'b1;
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   assert property (@(posedge clk_i) disable iff (!rst_ni)
      engine_start_o |=> !engine_start_o)
      else $error("engine start longer than one cycle");

   // Done only on the way out of terminate
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |-> (state_q == ST_TERMINATE) ##1 (state_q == ST_IDLE))
      else $error("done outside job end");

endmodule

/* out_packet_counter.sv */
// Output packet counter while the engine runs
// Output size and base presented during the run only
// Sink stream ready until the size is reached, sink start request

module out_packet_counter import panda_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        clear_i,
   input  logic        run_active_i,
   input  param_bank_t params_i,
   input  logic        c_valid_i,
   input  logic        c_ready_start_i,
   output logic        c_stream_ready_o,
   output logic        c_req_start_o,
   output word_t       c_trans_size_o,
   output word_t       c_base_o
);

   logic  clear_q;
   word_t count_q;
   logic  live;
   logic  at_size;

   assign c_trans_size_o = run_active_i ? params_i[PRM_OUT_N] : '0;
   assign c_base_o       = run_active_i ? params_i[PRM_OUT_ADDR] : '0;

   assign live    = run_active_i && !clear_q;
   assign at_size = (count_q == c_trans_size_o);

   assign c_stream_ready_o = live && !at_size && c_valid_i;    // Count stops at size
   assign c_req_start_o    = live && !at_size && (count_q == '0) && c_ready_start_i;

   // Clear follows the run flag with one cycle delay
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         clear_q <= 1'b1;
      end else if (clear_i) begin
         clear_q <= 1'b1;
      end else begin
         clear_q <= !run_active_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         count_q <= '0;
      end else if (clear_i || clear_q) begin
         count_q <= '0;
      end else if (c_stream_ready_o) begin
         count_q <= count_q + 1'b1;
      end
   end

endmodule

/* panda_ctrl_top.sv */
// Top level of the accelerator control sequencer
// Input side: parameter mux and input packet counter
// Processing: sequencer FSM
// Output side: output packet counter

module panda_ctrl_top import panda_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        clear_i,
   input  logic        start_i,
   input  logic        mode_i,           // MODE_CNN or MODE_FC
   input  param_bank_t params_i,
   input  logic        a_valid_i,
   input  logic        b_valid_i,
   input  logic        c_valid_i,
   input  logic        a_ready_start_i,
   input  logic        b_ready_start_i,
   input  logic        c_ready_start_i,
   input  logic        engine_done_i,
   output logic        stream_ready_o,
   output logic        wr_en_o,
   output mem_sel_t    mem_sel_o,
   output word_t       trans_size_o,
   output word_t       a_base_o,
   output word_t       d_base_o,
   output logic        a_req_start_o,
   output logic        b_req_start_o,
   output logic        c_stream_ready_o,
   output logic        c_req_start_o,
   output word_t       c_trans_size_o,
   output word_t       c_base_o,
   output logic        engine_clear_o,
   output logic        engine_enable_o,
   output logic        engine_start_o,
   output logic        done_o
);

   fsm_state_t state;
   logic       load_active;
   logic       load_clear;
   logic       run_active;
   logic       count_zero;
   logic       complete;

   load_param_mux load_param_mux_inst (
      .state_i      (state),
      .params_i     (params_i),
      .mode_i       (mode_i),
      .trans_size_o (trans_size_o),
      .a_base_o     (a_base_o),
      .d_base_o     (d_base_o),
      .mem_sel_o    (mem_sel_o)
   );

   in_packet_counter in_packet_counter_inst (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .clear_i        (clear_i),
      .load_clear_i   (load_clear),
      .load_active_i  (load_active),
      .trans_size_i   (trans_size_o),
      .a_valid_i      (a_valid_i),
      .b_valid_i      (b_valid_i),
      .stream_ready_o (stream_ready_o),
      .wr_en_o        (wr_en_o),
      .count_zero_o   (count_zero),
      .complete_o     (complete)
   );

   load_sequencer load_sequencer_inst (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .clear_i         (clear_i),
      .start_i         (start_i),
      .mode_i          (mode_i),
      .count_zero_i    (count_zero),
      .complete_i      (complete),
      .a_ready_start_i (a_ready_start_i),
      .b_ready_start_i (b_ready_start_i),
      .engine_done_i   (engine_done_i),
      .state_o         (state),
      .load_active_o   (load_active),
      .load_clear_o    (load_clear),
      .run_active_o    (run_active),
      .a_req_start_o   (a_req_start_o),
      .b_req_start_o   (b_req_start_o),
      .engine_clear_o  (engine_clear_o),
      .engine_enable_o (engine_enable_o),
      .engine_start_o  (engine_start_o),
      .done_o          (done_o)
   );

   out_packet_counter out_packet_counter_inst (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .clear_i          (clear_i),
      .run_active_i     (run_active),
      .params_i         (params_i),
      .c_valid_i        (c_valid_i),
      .c_ready_start_i  (c_ready_start_i),
      .c_stream_ready_o (c_stream_ready_o),
      .c_req_start_o    (c_req_start_o),
      .c_trans_size_o   (c_trans_size_o),
      .c_base_o         (c_base_o)
   );

endmodule

/* panda_pkg.sv */
// Shared definitions of the accelerator control sequencer
// Word and parameter bank types, bank indices
// Memory select and sequencer state encodings, engine mode flag values

package panda_pkg;

   typedef logic [31:0] word_t;        // Size, address or parameter word

   localparam int NUM_PARAMS = 23;     // 7 regions x 3 words, plus output size and address

   typedef word_t [NUM_PARAMS-1:0] param_bank_t;

   // Per region: packet count, address stream base, data stream base
   localparam int PRM_CONFIG_N         = 0;
   localparam int PRM_CONFIG_AADDR     = 1;
   localparam int PRM_CONFIG_DADDR     = 2;
   localparam int PRM_INSTR_N          = 3;
   localparam int PRM_INSTR_AADDR      = 4;
   localparam int PRM_INSTR_DADDR      = 5;
   localparam int PRM_LUT_N            = 6;
   localparam int PRM_LUT_AADDR        = 7;
   localparam int PRM_LUT_DADDR        = 8;
   localparam int PRM_SPARSITY_N       = 9;
   localparam int PRM_SPARSITY_AADDR   = 10;
   localparam int PRM_SPARSITY_DADDR   = 11;
   localparam int PRM_ACTIVATION_N     = 12;
   localparam int PRM_ACTIVATION_AADDR = 13;
   localparam int PRM_ACTIVATION_DADDR = 14;
   localparam int PRM_WCONV_N          = 15;
   localparam int PRM_WCONV_AADDR      = 16;
   localparam int PRM_WCONV_DADDR      = 17;
   localparam int PRM_WFC_N            = 18;
   localparam int PRM_WFC_AADDR        = 19;
   localparam int PRM_WFC_DADDR        = 20;
   localparam int PRM_OUT_N            = 21;   // Output packets per job
   localparam int PRM_OUT_ADDR         = 22;

   // Target memory of the write strobe
   typedef enum logic [2:0] {
      SEL_NULL,
      SEL_CONFIG,
      SEL_INSTR,
      SEL_LUT,
      SEL_SPARSITY,
      SEL_ACTIVATION,
      SEL_WCONV,
      SEL_WFC
   } mem_sel_t;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_LOAD_CONFIG,
      ST_LOAD_INSTR,
      ST_LOAD_LUT,
      ST_LOAD_SPARSITY,
      ST_LOAD_ACTIVATION,
      ST_LOAD_WCONV,
      ST_LOAD_WFC,
      ST_RUN,          // One cycle engine start
      ST_RUNNING,
      ST_TERMINATE
   } fsm_state_t;

   // Engine mode flag
   localparam logic MODE_FC  = 1'b0;
   localparam logic MODE_CNN = 1'b1;

endpackage

/* tb_panda_ctrl.sv */
// Testbench of the accelerator control sequencer
// Job table: region sizes, mode, output size, engine delay, abort point
// Random stream stubs, write monitor, clear check, timeout, closing report

module tb_panda_ctrl import panda_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_JOBS    = 5;
   localparam int NUM_REGIONS = 7;

   // Sizes per region: config, instr, LUT, sparsity, activation, conv, FC
   localparam int JOB_SIZE [NUM_JOBS][NUM_REGIONS] = '{
      '{3, 2, 4, 1, 2, 5, 0},
      '{1, 0, 2, 3, 0, 5, 4},   // FC job, conv size ignored
      '{0, 0, 0, 0, 0, 0, 0},   // Every region skipped
      '{2, 1, 1, 2, 3, 0, 6},
      '{2, 3, 1, 1, 2, 2, 1}
   };
   localparam logic JOB_MODE  [NUM_JOBS] = '{MODE_CNN, MODE_FC, MODE_CNN, MODE_FC, MODE_CNN};
   localparam int   JOB_OUT_N [NUM_JOBS] = '{4, 2, 0, 3, 5};
   localparam int   JOB_DELAY [NUM_JOBS] = '{3, 0, 1, 2, 4};  // Last output to engine done
   localparam int   JOB_ABORT [NUM_JOBS] = '{0, 0, 0, 4, 0};  // Clear after N writes, 0 none

   localparam mem_sel_t REGION_SEL [NUM_REGIONS] = '{SEL_CONFIG, SEL_INSTR, SEL_LUT,
      SEL_SPARSITY, SEL_ACTIVATION, SEL_WCONV, SEL_WFC};

   logic        clk_i, rst_ni, clear_i, start_i, mode_i;
   param_bank_t params_i;
   logic        a_valid_i, b_valid_i, c_valid_i;
   logic        a_ready_start_i, b_ready_start_i, c_ready_start_i;
   logic        engine_done_i;
   logic        stream_ready_o, wr_en_o;
   mem_sel_t    mem_sel_o;
   word_t       trans_size_o, a_base_o, d_base_o;
   logic        a_req_start_o, b_req_start_o, c_stream_ready_o, c_req_start_o;
   word_t       c_trans_size_o, c_base_o;
   logic        engine_clear_o, engine_enable_o, engine_start_o, done_o;

   int   seed = 5;
   int   checks = 0;
   int   errors = 0;
   int   cycles = 0;
   int   timeout_limit;
   int   cur_job = 0;
   int   exp_region[$];      // Region index per expected write
   int   wr_idx, start_cnt, out_cnt, done_cnt;
   logic engine_done_seen;

   panda_ctrl_top panda_ctrl_top_inst (
      .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .start_i(start_i),
      .mode_i(mode_i), .params_i(params_i),
      .a_valid_i(a_valid_i), .b_valid_i(b_valid_i), .c_valid_i(c_valid_i),
      .a_ready_start_i(a_ready_start_i), .b_ready_start_i(b_ready_start_i),
      .c_ready_start_i(c_ready_start_i), .engine_done_i(engine_done_i),
      .stream_ready_o(stream_ready_o), .wr_en_o(wr_en_o), .mem_sel_o(mem_sel_o),
      .trans_size_o(trans_size_o), .a_base_o(a_base_o), .d_base_o(d_base_o),
      .a_req_start_o(a_req_start_o), .b_req_start_o(b_req_start_o),
      .c_stream_ready_o(c_stream_ready_o), .c_req_start_o(c_req_start_o),
      .c_trans_size_o(c_trans_size_o), .c_base_o(c_base_o),
      .engine_clear_o(engine_clear_o), .engine_enable_o(engine_enable_o),
      .engine_start_o(engine_start_o), .done_o(done_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;   // 4 ns period
   end

   // Distinct address and data bases per job and region
   function automatic word_t a_addr_of(input int job, input int region);
      return 32'h1000_0000 + word_t'(region) * 32'h10_0000 + word_t'(job) * 32'h400;
   endfunction

   function automatic word_t d_addr_of(input int job, input int region);
      return 32'h2000_0000 + word_t'(region) * 32'h10_0000 + word_t'(job) * 32'h800;
   endfunction

   function automatic word_t out_addr_of(input int job);
      return 32'h3000_0000 + word_t'(job) * 32'h100;
   endfunction

   // Three words per region: size, address base, data base
   function automatic param_bank_t make_params(input int job);
      param_bank_t p;
      p = '0;
      for (int r = 0; r < NUM_REGIONS; r++) begin
         p[3*r]     = word_t'(JOB_SIZE[job][r]);
         p[3*r + 1] = a_addr_of(job, r);
         p[3*r + 2] = d_addr_of(job, r);
      end
      p[PRM_OUT_N]    = word_t'(JOB_OUT_N[job]);
      p[PRM_OUT_ADDR] = out_addr_of(job);
      return p;
   endfunction

   task automatic check_val(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // Stream stubs, new values each falling edge
   initial begin : stream_stubs
      a_valid_i       = 1'b0;
      b_valid_i       = 1'b0;
      c_valid_i       = 1'b0;
      a_ready_start_i = 1'b1;
      b_ready_start_i = 1'b1;
      c_ready_start_i = 1'b1;
      forever begin
         @(negedge clk_i);
         a_valid_i       = ($random(seed) & 3) != 0;   // About three cycles in four
         b_valid_i       = ($random(seed) & 3) != 0;
         c_valid_i       = ($random(seed) & 3) != 0;
         a_ready_start_i = ($random(seed) & 7) != 0;   // Streamer busy now and then
         b_ready_start_i = ($random(seed) & 7) != 0;
         c_ready_start_i = ($random(seed) & 7) != 0;
      end
   end

   // Monitor samples on the rising edge, outputs settled since the falling one
   always @(posedge clk_i) begin : monitor
      int r;
      if (rst_ni) begin
         if (start_i) begin   // New job
            wr_idx           = 0;
            start_cnt        = 0;
            out_cnt          = 0;
            done_cnt         = 0;
            engine_done_seen = 1'b0;
         end
         if (engine_done_i) engine_done_seen = 1'b1;
         if (stream_ready_o)
            check_val("stream_ready_o with both valids", word_t'(a_valid_i && b_valid_i), 1);
         if (a_req_start_o)
            check_val("a_req_start_o with streamers ready",
                      word_t'(a_ready_start_i && b_ready_start_i), 1);
         if (b_req_start_o)
            check_val("b_req_start_o with streamers ready",
                      word_t'(a_ready_start_i && b_ready_start_i), 1);
         if (c_req_start_o) check_val("c_req_start_o with c ready", word_t'(c_ready_start_i), 1);
         if (wr_en_o) begin
            if (wr_idx < exp_region.size()) begin
               r = exp_region[wr_idx];
               check_val("mem_sel_o", word_t'(mem_sel_o), word_t'(REGION_SEL[r]));
               check_val("trans_size_o", trans_size_o, word_t'(JOB_SIZE[cur_job][r]));
               check_val("a_base_o", a_base_o, a_addr_of(cur_job, r));
               check_val("d_base_o", d_base_o, d_addr_of(cur_job, r));
            end else begin
               check_val("wr_en_o past last load write", word_t'(wr_en_o), 0);
            end
            wr_idx++;
         end
         if (engine_start_o) begin
            start_cnt++;
            check_val("writes before engine_start_o", wr_idx, exp_region.size());
         end
         if (c_stream_ready_o) begin
            out_cnt++;
            check_val("c_valid_i at c_stream_ready_o", word_t'(c_valid_i), 1);
            check_val("c_trans_size_o", c_trans_size_o, word_t'(JOB_OUT_N[cur_job]));
            check_val("c_base_o", c_base_o, out_addr_of(cur_job));
         end
         if (done_o) begin
            done_cnt++;
            check_val("engine_done_i before done_o", word_t'(engine_done_seen), 1);
         end
      end
   end

   always @(posedge clk_i) begin : watchdog
      cycles++;
      if (cycles > timeout_limit) begin
         $display("Timeout: jobs not finished within %0d cycles", timeout_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // Clear in the middle of a load, DUT must fall back to idle
   task automatic abort_load();
      int w;
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
      @(posedge clk_i);
      check_val("engine_clear_o after clear", word_t'(engine_clear_o), 1);
      check_val("engine_enable_o after clear", word_t'(engine_enable_o), 0);
      check_val("wr_en_o after clear", word_t'(wr_en_o), 0);
      check_val("done_o after clear", word_t'(done_o), 0);
      check_val("mem_sel_o after clear", word_t'(mem_sel_o), word_t'(SEL_NULL));
      check_val("engine_start_o pulses in aborted job", start_cnt, 0);
      w = wr_idx;
      repeat (4) @(negedge clk_i);
      check_val("writes while idle after clear", wr_idx, w);
   endtask

   task automatic run_job(input int job);
      int weight;
      cur_job  = job;
      params_i = make_params(job);
      mode_i   = JOB_MODE[job];
      weight   = (JOB_MODE[job] == MODE_CNN) ? 5 : 6;   // Weight region by mode
      exp_region.delete();
      for (int r = 0; r < 5; r++) begin
         repeat (JOB_SIZE[job][r]) exp_region.push_back(r);
      end
      repeat (JOB_SIZE[job][weight]) exp_region.push_back(weight);
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      if (JOB_ABORT[job] != 0) begin
         while (wr_idx < JOB_ABORT[job]) @(negedge clk_i);
         abort_load();
      end else begin
         while (start_cnt == 0) @(negedge clk_i);
         while (out_cnt < JOB_OUT_N[job]) @(negedge clk_i);   // Engine drains its output
         repeat (JOB_DELAY[job]) @(negedge clk_i);
         engine_done_i = 1'b1;
         @(negedge clk_i);
         engine_done_i = 1'b0;
         while (done_cnt == 0) @(negedge clk_i);
         repeat (3) @(negedge clk_i);   // Catch late extra pulses
         check_val("engine_start_o pulses", start_cnt, 1);
         check_val("load writes", wr_idx, exp_region.size());
         check_val("output acceptances", out_cnt, JOB_OUT_N[job]);
         check_val("done_o pulses", done_cnt, 1);
      end
   endtask

   initial begin : main
      int total;
      rst_ni        = 1'b0;
      clear_i       = 1'b0;
      start_i       = 1'b0;
      mode_i        = MODE_FC;
      params_i      = '0;
      engine_done_i = 1'b0;
      total         = 0;
      for (int j = 0; j < NUM_JOBS; j++) begin
         for (int r = 0; r < NUM_REGIONS; r++) total += JOB_SIZE[j][r];
         total += JOB_OUT_N[j];
      end
      timeout_limit = 10 * total + 300;
      repeat (10) @(negedge clk_i);
      rst_ni = 1'b1;
      repeat (2) @(negedge clk_i);
      for (int j = 0; j < NUM_JOBS; j++) begin
         run_job(j);
      end
      repeat (3) @(negedge clk_i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
